//--- design/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

  typedef logic [1:0] grand_op_t;
  typedef logic [1:0] alu_op_t;

  // Operation groups, used by the ALU output mux
  localparam grand_op_t GTYPE_LI  = 2'b00; // Logic ops
  localparam grand_op_t GTYPE_INT = 2'b01; // Add/sub, LI extras or multiply
  localparam grand_op_t GTYPE_SFT = 2'b10;
  localparam grand_op_t GTYPE_CMP = 2'b11;

  // Logic group
  localparam alu_op_t OP_NOR = 2'b00;
  localparam alu_op_t OP_AND = 2'b01;
  localparam alu_op_t OP_OR  = 2'b10;
  localparam alu_op_t OP_XOR = 2'b11;

  // INT group, only op[1] is decoded
  localparam alu_op_t OP_ADD = 2'b00;
  localparam alu_op_t OP_SUB = 2'b10;

  // LI extras share the INT slot when no adder is present
  localparam alu_op_t OP_LUI     = 2'b01;
  localparam alu_op_t OP_PCPLUS4 = 2'b10;
  localparam alu_op_t OP_PCADDUI = 2'b11;

  localparam alu_op_t OP_SLL = 2'b00;
  localparam alu_op_t OP_SRL = 2'b01;
  localparam alu_op_t OP_SRA = 2'b10;

  localparam alu_op_t OP_SLTU = 2'b00;
  localparam alu_op_t OP_SLT  = 2'b01; // Signed compare

endpackage

`default_nettype wire

//--- design/exe_pkg.sv
`default_nettype none

package exe_pkg;

  import decoder_pkg::*;

  // Instruction tag, carried unchanged from issue to result
  typedef logic [5:0] exe_tag_t;

  // Issue payload of one lane
  typedef struct packed {
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] pc;
    grand_op_t   grand_op;
    alu_op_t     op;
    exe_tag_t    tag;
  } exe_issue_t;

  typedef struct packed {
    logic [31:0] res;
    exe_tag_t    tag;
  } exe_result_t;

endpackage

`default_nettype wire

//--- design/detachable_alu.sv
`timescale 1ns/1ps
`default_nettype none

module detachable_alu import decoder_pkg::*; #(
  parameter bit USE_LI  = 1'b0,
  parameter bit USE_INT = 1'b1,
  parameter bit USE_MUL = 1'b0,
  parameter bit USE_SFT = 1'b1,
  parameter bit USE_CMP = 1'b1
) (
  input  logic [31:0] mul_i,
  input  logic [31:0] r0_i,
  input  logic [31:0] r1_i,
  input  logic [31:0] pc_i,
  input  grand_op_t   grand_op_i,
  input  alu_op_t     op_i,
  output logic [31:0] res_o
);

  localparam bit HAS_G1 = USE_LI || USE_INT || USE_MUL;
  localparam bit HAS_HI = USE_SFT || USE_CMP; // Groups 2 and 3

  logic [31:0] g0_res;
  logic [31:0] g1_res;
  logic [31:0] g2_res;
  logic [31:0] g3_res;

  // Output mux, narrowed to the groups that exist
  if (HAS_G1 && HAS_HI) begin : g_mux_full
    always_comb begin
      case (grand_op_i)
        GTYPE_INT: res_o = g1_res;
        GTYPE_SFT: res_o = g2_res;
        GTYPE_CMP: res_o = g3_res;
        default:   res_o = g0_res;
      endcase
    end
  end else if (HAS_G1) begin : g_mux_lo
    assign res_o = grand_op_i[0] ? g1_res : g0_res;
  end else if (HAS_HI) begin : g_mux_hi
    always_comb begin
      if (!grand_op_i[1]) begin
        res_o = g0_res;
      end else if (USE_SFT && USE_CMP) begin
        res_o = grand_op_i[0] ? g3_res : g2_res;
      end else if (USE_SFT) begin
        res_o = g2_res;
      end else begin
        res_o = g3_res;
      end
    end
  end else begin : g_mux_none
    assign res_o = g0_res; // Logic group only
  end

  if (USE_LI) begin : g_logic
    always_comb begin
      case (op_i)
        OP_NOR:  g0_res = ~(r1_i | r0_i);
        OP_AND:  g0_res = r1_i & r0_i;
        OP_OR:   g0_res = r1_i | r0_i;
        default: g0_res = r1_i ^ r0_i;
      endcase
    end
  end else begin : g_no_logic
    assign g0_res = '0;
  end

  // Adder takes priority over the LI extras and the multiplier
  if (USE_INT) begin : g_int
    assign g1_res = op_i[1] ? (r1_i - r0_i) : (r1_i + r0_i);
  end else if (USE_LI) begin : g_li
    always_comb begin
      case (op_i)
        OP_PCPLUS4: g1_res = pc_i + 32'd4;
        OP_PCADDUI: g1_res = pc_i + r0_i;
        default:    g1_res = {r0_i[19:0], 12'd0}; // LUI
      endcase
    end
  end else if (USE_MUL) begin : g_mul
    assign g1_res = mul_i; // Product from the lane multiplier
  end else begin : g_no_g1
    assign g1_res = '0;
  end

  if (USE_SFT) begin : g_sft
    always_comb begin
      case (op_i)
        OP_SRL:  g2_res = r1_i >> r0_i[4:0];
        OP_SRA:  g2_res = $signed(r1_i) >>> r0_i[4:0];
        default: g2_res = r1_i << r0_i[4:0];
      endcase
    end
  end else begin : g_no_sft
    assign g2_res = '0;
  end

  if (USE_CMP) begin : g_cmp
    logic lt;

    // op[0] picks the signed compare
    assign lt = op_i[0] ? ($signed(r1_i) < $signed(r0_i)) : (r1_i < r0_i);
    assign g3_res = {31'd0, lt};
  end else begin : g_no_cmp
    assign g3_res = '0;
  end

endmodule

`default_nettype wire

//--- design/exe_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module exe_multiplier (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        en_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  output logic [31:0] prod_o
);

  logic [31:0] a_q;
  logic [31:0] b_q;
  logic [31:0] prod_q;

  // Operand capture
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      a_q <= '0;
      b_q <= '0;
    end else if (en_i) begin
      a_q <= a_i;
      b_q <= b_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      prod_q <= '0;
    end else if (en_i) begin
      prod_q <= a_q * b_q; // Low 32 bits only
    end
  end

  assign prod_o = prod_q;

endmodule

`default_nettype wire

//--- design/exe_lane.sv
`timescale 1ns/1ps
`default_nettype none

module exe_lane import exe_pkg::*, decoder_pkg::*; #(
  parameter bit  USE_LI  = 1'b0,
  parameter bit  USE_INT = 1'b1,
  parameter bit  USE_MUL = 1'b0,
  parameter bit  USE_SFT = 1'b1,
  parameter bit  USE_CMP = 1'b1,
  parameter type tag_t   = exe_tag_t
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        issue_valid_i,
  output logic        issue_ready_o,
  input  exe_issue_t  issue_i,
  output logic        res_valid_o,
  input  logic        res_ready_i,
  output exe_result_t res_o
);

  localparam int DEPTH = USE_MUL ? 2 : 1; // Second stage waits for the product

  // Groups the ALU can select, indexed by grand_op
  localparam logic [3:0] GRP_EN = {USE_CMP, USE_SFT, USE_LI | USE_INT | USE_MUL, 1'b1};

  typedef struct packed {
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] pc;
    grand_op_t   grand_op;
    alu_op_t     op;
    tag_t        tag;
  } stage_t;

  stage_t [DEPTH-1:0] stg_q;
  logic   [DEPTH-1:0] stg_vld_q;
  logic               advance;
  logic [31:0]        mul_res;
  logic [31:0]        alu_res;
  logic               res_vld_q;
  exe_result_t        res_q;

  // Whole lane moves when the output slot is free or being drained
  assign advance       = !res_vld_q || res_ready_i;
  assign issue_ready_o = advance;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      stg_vld_q <= '0;
      res_vld_q <= 1'b0;
    end else if (advance) begin
      stg_vld_q[0] <= issue_valid_i;
      for (int i = 1; i < DEPTH; i++) begin
        stg_vld_q[i] <= stg_vld_q[i-1];
      end
      res_vld_q <= stg_vld_q[DEPTH-1];
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      stg_q[0].r0       <= issue_i.r0;
      stg_q[0].r1       <= issue_i.r1;
      stg_q[0].pc       <= issue_i.pc;
      stg_q[0].grand_op <= issue_i.grand_op;
      stg_q[0].op       <= issue_i.op;
      stg_q[0].tag      <= issue_i.tag;
      for (int i = 1; i < DEPTH; i++) begin
        stg_q[i] <= stg_q[i-1];
      end
      res_q.res <= alu_res;
      res_q.tag <= stg_q[DEPTH-1].tag;
    end
  end

  if (USE_MUL) begin : g_mul
    // Fed at issue, so the product lines up with the last stage
    exe_multiplier i_exe_multiplier (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .en_i    (advance),
      .a_i     (issue_i.r0),
      .b_i     (issue_i.r1),
      .prod_o  (mul_res)
    );
  end else begin : g_no_mul
    assign mul_res = '0;
  end

  detachable_alu #(
    .USE_LI  (USE_LI),
    .USE_INT (USE_INT),
    .USE_MUL (USE_MUL),
    .USE_SFT (USE_SFT),
    .USE_CMP (USE_CMP)
  ) i_detachable_alu (
    .mul_i      (mul_res),
    .r0_i       (stg_q[DEPTH-1].r0),
    .r1_i       (stg_q[DEPTH-1].r1),
    .pc_i       (stg_q[DEPTH-1].pc),
    .grand_op_i (stg_q[DEPTH-1].grand_op),
    .op_i       (stg_q[DEPTH-1].op),
    .res_o      (alu_res)
  );

  assign res_valid_o = res_vld_q;
  assign res_o       = res_q;

  // A stalled result must not move
  a_res_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    res_vld_q && !res_ready_i |=> res_vld_q && $stable(res_q))
    else $error("exe_lane: held result changed under back-pressure");

  a_grp_en: assert property (@(posedge clk) disable iff (!rst_n_i)
    stg_vld_q[DEPTH-1] |-> GRP_EN[stg_q[DEPTH-1].grand_op])
    else $error("exe_lane: grand_op selects a removed ALU group");

endmodule

`default_nettype wire

//--- design/exe_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exe_cluster import exe_pkg::*; #(
  // Lane 0 is the full ALU
  parameter bit L0_USE_LI  = 1'b1,
  parameter bit L0_USE_INT = 1'b1,
  parameter bit L0_USE_MUL = 1'b0,
  parameter bit L0_USE_SFT = 1'b1,
  parameter bit L0_USE_CMP = 1'b1,
  // Lane 1 is multiply and shift
  parameter bit L1_USE_LI  = 1'b0,
  parameter bit L1_USE_INT = 1'b0,
  parameter bit L1_USE_MUL = 1'b1,
  parameter bit L1_USE_SFT = 1'b1,
  parameter bit L1_USE_CMP = 1'b0
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        lane0_issue_valid_i,
  output logic        lane0_issue_ready_o,
  input  exe_issue_t  lane0_issue_i,
  output logic        lane0_res_valid_o,
  input  logic        lane0_res_ready_i,
  output exe_result_t lane0_res_o,
  input  logic        lane1_issue_valid_i,
  output logic        lane1_issue_ready_o,
  input  exe_issue_t  lane1_issue_i,
  output logic        lane1_res_valid_o,
  input  logic        lane1_res_ready_i,
  output exe_result_t lane1_res_o
);

  exe_lane #(
    .USE_LI  (L0_USE_LI),
    .USE_INT (L0_USE_INT),
    .USE_MUL (L0_USE_MUL),
    .USE_SFT (L0_USE_SFT),
    .USE_CMP (L0_USE_CMP),
    .tag_t   (exe_tag_t)
  ) i_exe_lane0 (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (lane0_issue_valid_i),
    .issue_ready_o (lane0_issue_ready_o),
    .issue_i       (lane0_issue_i),
    .res_valid_o   (lane0_res_valid_o),
    .res_ready_i   (lane0_res_ready_i),
    .res_o         (lane0_res_o)
  );

  exe_lane #(
    .USE_LI  (L1_USE_LI),
    .USE_INT (L1_USE_INT),
    .USE_MUL (L1_USE_MUL),
    .USE_SFT (L1_USE_SFT),
    .USE_CMP (L1_USE_CMP),
    .tag_t   (exe_tag_t)
  ) i_exe_lane1 (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (lane1_issue_valid_i),
    .issue_ready_o (lane1_issue_ready_o),
    .issue_i       (lane1_issue_i),
    .res_valid_o   (lane1_res_valid_o),
    .res_ready_i   (lane1_res_ready_i),
    .res_o         (lane1_res_o)
  );

endmodule

`default_nettype wire

//--- test/tb_exe_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exe_cluster import decoder_pkg::*, exe_pkg::*; ();

  localparam int NUM_ISSUES = 2000;
  localparam int BURST      = 500; // Issues per lane sent with res_ready held high
  localparam int TIMEOUT_NS = NUM_ISSUES * 4 * 8 + 200 * 8;

  logic        clk;
  logic        rst_n;
  logic [1:0]  issue_valid;
  logic [1:0]  issue_ready;
  exe_issue_t  issue_pl [2];
  logic [1:0]  res_valid;
  logic [1:0]  res_ready;
  exe_result_t res_pl [2];

  integer      seed = 22498;
  exe_issue_t  exp_q [2][$];
  logic [1:0]  fired;
  logic [1:0]  held;
  exe_result_t held_res [2];
  int          sent [2];
  int          accepted [2];
  exe_tag_t    next_tag [2];

  exe_cluster i_exe_cluster (
    .clk                 (clk),
    .rst_n_i             (rst_n),
    .lane0_issue_valid_i (issue_valid[0]),
    .lane0_issue_ready_o (issue_ready[0]),
    .lane0_issue_i       (issue_pl[0]),
    .lane0_res_valid_o   (res_valid[0]),
    .lane0_res_ready_i   (res_ready[0]),
    .lane0_res_o         (res_pl[0]),
    .lane1_issue_valid_i (issue_valid[1]),
    .lane1_issue_ready_o (issue_ready[1]),
    .lane1_issue_i       (issue_pl[1]),
    .lane1_res_valid_o   (res_valid[1]),
    .lane1_res_ready_i   (res_ready[1]),
    .lane1_res_o         (res_pl[1])
  );

  always #4 clk = ~clk;

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Bit order {li, int, mul, sft, cmp}
  function automatic logic [4:0] lane_uses(input int lane);
    return (lane == 0) ? 5'b11011 : 5'b00110;
  endfunction

  // Corner values mixed in for shifts, overflow and signed compare
  function automatic logic [31:0] pick_operand();
    case (rand_below(6))
      0:       return 32'd0;
      1:       return 32'd31;
      2:       return 32'h8000_0000 | $random(seed);
      3:       return 32'h7fff_ffff;
      default: return $random(seed);
    endcase
  endfunction

  function automatic exe_issue_t new_issue(input int lane, input exe_tag_t tag);
    exe_issue_t it;
    int         pick;
    it.r0  = pick_operand();
    it.r1  = pick_operand();
    it.pc  = $random(seed);
    it.tag = tag;
    pick   = rand_below(10);
    if (lane == 0) begin
      it.grand_op = grand_op_t'(pick % 4);
    end else begin
      // Lane 1 has no logic group, so 00 must give zero
      it.grand_op = (pick == 0) ? GTYPE_LI : (pick < 6) ? GTYPE_INT : GTYPE_SFT;
    end
    case (it.grand_op)
      GTYPE_INT: it.op = rand_below(2) ? OP_SUB : OP_ADD;
      GTYPE_SFT: it.op = alu_op_t'(rand_below(3));
      GTYPE_CMP: it.op = rand_below(2) ? OP_SLT : OP_SLTU;
      default:   it.op = alu_op_t'(rand_below(4));
    endcase
    return it;
  endfunction

  // Expected result from the group rules of the execute cluster
  function automatic logic [31:0] ref_result(input exe_issue_t it, input logic [4:0] uses);
    logic [31:0] a;
    logic [31:0] b;
    a = it.r0;
    b = it.r1;
    case (it.grand_op)
      GTYPE_LI: begin
        if (!uses[4]) return 32'd0;
        case (it.op)
          OP_NOR:  return ~(b | a);
          OP_AND:  return b & a;
          OP_OR:   return b | a;
          default: return b ^ a;
        endcase
      end
      GTYPE_INT: begin
        if (uses[3]) return (it.op == OP_SUB) ? b - a : b + a;
        if (uses[4]) begin
          if (it.op == OP_PCPLUS4) return it.pc + 32'd4;
          if (it.op == OP_PCADDUI) return it.pc + a;
          return {a[19:0], 12'd0};
        end
        if (uses[2]) return a * b;
        return 32'd0;
      end
      GTYPE_SFT: begin
        if (!uses[1]) return 32'd0;
        if (it.op == OP_SRL) return b >> a[4:0];
        if (it.op == OP_SRA) return $signed(b) >>> a[4:0];
        return b << a[4:0];
      end
      default: begin
        if (!uses[0]) return 32'd0;
        if (it.op == OP_SLT) return {31'd0, $signed(b) < $signed(a)};
        return {31'd0, b < a};
      end
    endcase
  endfunction

  function automatic string test_name(input int lane, input grand_op_t g);
    string grp;
    case (g)
      GTYPE_LI:  grp = "LOGIC";
      GTYPE_INT: grp = (lane == 1) ? "MUL" : "INT";
      GTYPE_SFT: grp = "SFT";
      default:   grp = "CMP";
    endcase
    return $sformatf("lane%0d %s", lane, grp);
  endfunction

  task automatic check_result(input int lane, input exe_issue_t it, input exe_result_t got);
    logic [31:0] exp_res;
    exp_res = ref_result(it, lane_uses(lane));
    assert (got.tag == it.tag) else
      stop_with_error($sformatf("ERROR %s tag: expected %h, actual %h",
        test_name(lane, it.grand_op), it.tag, got.tag));
    assert (got.res == exp_res) else
      stop_with_error($sformatf("ERROR %s: expected %h, actual %h",
        test_name(lane, it.grand_op), exp_res, got.res));
  endtask

  // Scoreboard, samples both ports on the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      for (int l = 0; l < 2; l++) begin
        fired[l] = issue_valid[l] && issue_ready[l];
        if (fired[l]) begin
          exp_q[l].push_back(issue_pl[l]);
          accepted[l]++;
        end
        assert (issue_ready[l] == (!res_valid[l] || res_ready[l])) else
          stop_with_error($sformatf("ERROR lane%0d issue_ready: expected %b, actual %b",
            l, !res_valid[l] || res_ready[l], issue_ready[l]));
        if (held[l]) begin
          assert (res_valid[l] && res_pl[l] == held_res[l]) else
            stop_with_error($sformatf("ERROR lane%0d held result: expected %h, actual %h",
              l, held_res[l], res_pl[l]));
        end
        if (res_valid[l] && res_ready[l]) begin
          assert (exp_q[l].size() != 0) else
            stop_with_error($sformatf("lane%0d produced a result with no issue pending", l));
          check_result(l, exp_q[l].pop_front(), res_pl[l]);
        end
        held[l]     = res_valid[l] && !res_ready[l];
        held_res[l] = res_pl[l];
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: results stopped arriving");
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    issue_valid = '0;
    res_ready   = '0; // Reset state must not rely on res_ready
    fired       = '0;
    held        = '0;
    for (int l = 0; l < 2; l++) begin
      issue_pl[l]    = '0;
      held_res[l]    = '0;
      sent[l]        = 0;
      accepted[l]    = 0;
      next_tag[l]    = '0;
    end
    for (int c = 0; c <= 10; c++) begin
      @(negedge clk);
      if (c == 9) rst_n = 1'b1;
      assert (res_valid == 2'b00 && issue_ready == 2'b11) else
        stop_with_error($sformatf("ERROR reset state: expected 00/11, actual %b/%b",
          res_valid, issue_ready));
    end
    while (accepted[0] < NUM_ISSUES || accepted[1] < NUM_ISSUES ||
           exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      for (int l = 0; l < 2; l++) begin
        if (fired[l]) issue_valid[l] = 1'b0;
        if (!issue_valid[l] && sent[l] < NUM_ISSUES &&
            (sent[l] < BURST || rand_below(10) != 0)) begin
          issue_pl[l]    = new_issue(l, next_tag[l]);
          issue_valid[l] = 1'b1;
          next_tag[l]++;
          sent[l]++;
        end
        res_ready[l] = (sent[l] < BURST) || (rand_below(10) >= 3);
      end
      @(negedge clk);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- exe_cluster.f
design/decoder_pkg.sv
design/exe_pkg.sv
design/detachable_alu.sv
design/exe_multiplier.sv
design/exe_lane.sv
design/exe_cluster.sv
test/tb_exe_cluster.sv

//--- run.sh
#!/bin/sh
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f exe_cluster.f --top-module tb_exe_cluster -o sim_exe_cluster
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/sim_exe_cluster
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi

exit 0
